// ==== Makefile ====
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_udp_frame_tx
RTL_TOP    := udp_frame_tx
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_TEXT  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// One stimulus row and its expected frame length with FCS
typedef struct {
    string       name;
    logic [47:0] mac_destination;
    logic [47:0] mac_source;
    logic [31:0] ipv4_source;
    logic [31:0] ipv4_destination;
    logic [15:0] ipv4_identification;
    logic [15:0] ipv4_flags;
    logic [15:0] udp_source;
    logic [15:0] udp_destination;
    logic [15:0] udp_checksum;
    logic [15:0] udp_payload_size;
    int          frame_bytes;
} frame_row_t;

// Ethernet CRC-32, reflected, one data bit per step
function automatic logic [31:0] crc32_byte(logic [31:0] crc, logic [7:0] data);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ 32'hEDB88320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

// Header words 4500, length, id, flags, 8011, addresses
function automatic logic [15:0] ipv4_checksum(frame_row_t row);
    logic [31:0] sum;
    sum = 32'h4500 + 32'(row.udp_payload_size) + 32'd28;
    sum = sum + 32'(row.ipv4_identification) + 32'(row.ipv4_flags) + 32'h8011;
    sum = sum + 32'(row.ipv4_source[31:16]) + 32'(row.ipv4_source[15:0]);
    sum = sum + 32'(row.ipv4_destination[31:16]) + 32'(row.ipv4_destination[15:0]);
    sum = 32'(sum[15:0]) + (sum >> 16);
    sum = 32'(sum[15:0]) + (sum >> 16);
    return ~sum[15:0];
endfunction

// Network order, top byte first
function automatic void push_field(logic [47:0] value, int count);
    for (int i = count - 1; i >= 0; i--) begin
        expected_bytes.push_back(8'(value >> (8 * i)));
    end
endfunction

function automatic void build_expected(frame_row_t row);
    logic [31:0] crc;
    expected_bytes.delete();
    push_field(row.mac_destination, 6);
    push_field(row.mac_source, 6);
    push_field(48'h0800, 2);
    push_field(48'h4500, 2);
    push_field(48'(row.udp_payload_size + 16'd28), 2);
    push_field(48'(row.ipv4_identification), 2);
    push_field(48'(row.ipv4_flags), 2);
    push_field(48'h8011, 2);
    push_field(48'(ipv4_checksum(row)), 2);
    push_field(48'(row.ipv4_source), 4);
    push_field(48'(row.ipv4_destination), 4);
    push_field(48'(row.udp_source), 2);
    push_field(48'(row.udp_destination), 2);
    push_field(48'(row.udp_payload_size + 16'd8), 2);
    push_field(48'(row.udp_checksum), 2);
    for (int i = 0; i < int'(row.udp_payload_size); i++) begin
        expected_bytes.push_back(buffer_mem[i[`FG_ADDR_W-1:0]]);
    end
    for (int i = int'(row.udp_payload_size); i < `FG_MIN_PAYLOAD; i++) begin
        expected_bytes.push_back(8'h00);
    end
    crc = 32'hFFFFFFFF;
    foreach (expected_bytes[i]) begin
        crc = crc32_byte(crc, expected_bytes[i]);
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
        expected_bytes.push_back(8'(crc >> (8 * i)));
    end
endfunction

`endif

// ==== dv/tb_udp_frame_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_gen_cfg.svh"

module tb_udp_frame_tx;

    localparam int CLOCK_HALF    = 50;
    localparam int RESET_CYCLES  = 10;
    localparam int READY_TIMEOUT = 100;
    localparam int FRAME_TIMEOUT = 1000;
    localparam int RANDOM_SEED   = 41109;
    localparam int ROW_COUNT     = 6;

    logic                  clock = 1'b0;
    logic                  reset_n;
    logic                  enable;
    logic [47:0]           mac_destination;
    logic [47:0]           mac_source;
    logic [31:0]           ipv4_source;
    logic [31:0]           ipv4_destination;
    logic [15:0]           ipv4_identification;
    logic [15:0]           ipv4_flags;
    logic [15:0]           udp_source;
    logic [15:0]           udp_destination;
    logic [15:0]           udp_checksum;
    logic [15:0]           udp_payload_size;
    logic [7:0]            buffer_read_data = 8'h00;
    logic                  ready;
    logic [`FG_ADDR_W-1:0] buffer_read_address;
    logic [7:0]            frame_data;
    logic                  frame_valid;
    logic                  frame_start;
    logic                  frame_last;

    logic [7:0] buffer_mem [`FG_BUFFER_BYTES];
    logic [7:0] expected_bytes [$];
    logic [7:0] actual_bytes [$];
    logic       aborted = 1'b0;
    logic       in_frame = 1'b0;
    int         stray_valid_count = 0;
    int         test_errors;
    int         error_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    `include "tb_frame_model.svh"

    frame_row_t table_rows [ROW_COUNT];

    udp_frame_tx i_dut (.*);

    always #CLOCK_HALF clock = ~clock;

    // Payload buffer with one cycle read latency
    always @(posedge clock) begin
        buffer_read_data <= buffer_mem[buffer_read_address];
    end

    // frame_valid outside frame_start..frame_last
    always @(negedge clock) begin
        if (frame_start) begin
            in_frame = 1'b1;
        end
        if (frame_valid && !in_frame) begin
            $display("ERROR: frame_valid high outside a frame at %0t", $time);
            stray_valid_count++;
        end
        if (frame_last) begin
            in_frame = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    function automatic void load_table();
        table_rows[0] = '{"size_1", 48'h0200_0000_0001, 48'h02aa_bbcc_ddee,
                          32'hc0a8_0001, 32'hc0a8_0002, 16'h0001, 16'h4000,
                          16'd1024, 16'd5000, 16'h0000, 16'd1, 64};
        table_rows[1] = '{"size_17", 48'hffff_ffff_ffff, 48'h0012_3456_789a,
                          32'h0a00_0001, 32'h0aff_ffff, 16'hbeef, 16'h0000,
                          16'd53, 16'd53, 16'h1234, 16'd17, 64};
        table_rows[2] = '{"size_18", 48'h0102_0304_0506, 48'h0a0b_0c0d_0e0f,
                          32'hac10_fe01, 32'hac10_0a0a, 16'hffff, 16'h4000,
                          16'd40000, 16'd123, 16'hffff, 16'd18, 64};
        table_rows[3] = '{"size_19", 48'h3333_0000_0001, 48'h0200_1122_3344,
                          32'hffff_ffff, 32'h0000_0000, 16'h8000, 16'h2000,
                          16'd68, 16'd67, 16'h0001, 16'd19, 65};
        table_rows[4] = '{"size_64", 48'h0050_5600_c008, 48'h00e0_4c68_0001,
                          32'h7f00_0001, 32'h7f00_0001, 16'h1357, 16'h4000,
                          16'd9, 16'd7, 16'habcd, 16'd64, 110};
        table_rows[5] = '{"size_300", 48'h9c8e_99aa_0102, 48'h8c85_90de_adbe,
                          32'hc612_3364, 32'hcb00_7107, 16'h0246, 16'h0000,
                          16'd65535, 16'd1, 16'h5a5a, 16'd300, 346};
    endfunction

    //////////////////////////////////////////////////
    // Drive and collect
    //////////////////////////////////////////////////

    // Cycles counts falling edges up to and including the one with ready
    task automatic wait_for_ready(output int cycles);
        logic ready_seen;
        cycles = 0;
        ready_seen = 1'b0;
        while (!ready_seen && cycles < READY_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            ready_seen = ready;
        end
        if (!ready_seen) begin
            $display("ERROR: ready did not rise within %0d cycles", READY_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic start_frame(input frame_row_t row);
        @(posedge clock);
        mac_destination     <= row.mac_destination;
        mac_source          <= row.mac_source;
        ipv4_source         <= row.ipv4_source;
        ipv4_destination    <= row.ipv4_destination;
        ipv4_identification <= row.ipv4_identification;
        ipv4_flags          <= row.ipv4_flags;
        udp_source          <= row.udp_source;
        udp_destination     <= row.udp_destination;
        udp_checksum        <= row.udp_checksum;
        udp_payload_size    <= row.udp_payload_size;
        enable              <= 1'b1;
        @(posedge clock);
        enable <= 1'b0;
    endtask

    task automatic collect_frame(input string name);
        int   cycles;
        int   ready_high;
        int   holes;
        logic started;
        logic done;
        cycles = 0;
        ready_high = 0;
        holes = 0;
        started = 1'b0;
        done = 1'b0;
        actual_bytes.delete();
        while (!done && cycles < FRAME_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            if (ready) begin
                ready_high++;
            end
            if (frame_start) begin
                started = 1'b1;
            end
            if (started) begin
                if (!frame_valid) begin
                    holes++;
                end
                actual_bytes.push_back(frame_data);
                done = frame_last;
            end
        end
        if (!done) begin
            $display("ERROR %s: no complete frame within %0d cycles", name, FRAME_TIMEOUT);
            aborted = 1'b1;
        end
        if (ready_high != 0) begin
            $display("ERROR %s: ready was high for %0d cycles during the frame", name, ready_high);
            test_errors++;
        end
        if (holes != 0) begin
            $display("ERROR %s: frame_valid dropped on %0d cycles inside the frame", name, holes);
            test_errors++;
        end
    endtask

    task automatic compare_frame(input frame_row_t row);
        if (actual_bytes.size() != row.frame_bytes) begin
            $display("FAIL %s: frame length expected %0d actual %0d",
                     row.name, row.frame_bytes, actual_bytes.size());
            test_errors++;
        end else if (expected_bytes.size() != actual_bytes.size()) begin
            $display("FAIL %s: model frame length expected %0d actual %0d",
                     row.name, row.frame_bytes, expected_bytes.size());
            test_errors++;
        end else begin
            for (int i = 0; i < expected_bytes.size(); i++) begin
                if (actual_bytes[i] != expected_bytes[i]) begin
                    $display("FAIL %s: byte %0d expected 0x%02h actual 0x%02h",
                             row.name, i, expected_bytes[i], actual_bytes[i]);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_row(input frame_row_t row);
        int gap;
        test_errors = 0;
        build_expected(row);
        start_frame(row);
        collect_frame(row.name);
        if (!aborted) begin
            compare_frame(row);
            wait_for_ready(gap);
            if (!aborted && gap < `FG_GAP_CYCLES) begin
                $display("FAIL %s: gap after frame_last expected at least %0d actual %0d",
                         row.name, `FG_GAP_CYCLES, gap);
                test_errors++;
            end
        end
        error_count += test_errors;
        if (test_errors == 0 && !aborted) begin
            tests_passed++;
            $display("test %s: passed", row.name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", row.name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int cycles;
        void'($urandom(RANDOM_SEED));
        for (int i = 0; i < `FG_BUFFER_BYTES; i++) begin
            buffer_mem[i[`FG_ADDR_W-1:0]] = 8'($urandom);
        end
        load_table();
        reset_n             = 1'b0;
        enable              = 1'b0;
        mac_destination     = '0;
        mac_source          = '0;
        ipv4_source         = '0;
        ipv4_destination    = '0;
        ipv4_identification = '0;
        ipv4_flags          = '0;
        udp_source          = '0;
        udp_destination     = '0;
        udp_checksum        = '0;
        udp_payload_size    = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;

        // Idle outputs once ready is up
        wait_for_ready(cycles);
        if (!aborted && (frame_valid || frame_start || frame_last ||
                         buffer_read_address != '0)) begin
            $display("ERROR reset_idle: frame outputs active before any enable");
            error_count++;
            tests_failed++;
            $display("test reset_idle: failed with 1 errors");
        end else if (!aborted) begin
            tests_passed++;
            $display("test reset_idle: passed");
        end

        for (int r = 0; r < ROW_COUNT && !aborted; r++) begin
            run_row(table_rows[r]);
        end

        error_count += stray_valid_count;
        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && !aborted && tests_passed == ROW_COUNT + 1) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
+incdir+dv
rtl/frame_gen_pkg.sv
rtl/frame_hdr_if.sv
rtl/frame_stream_if.sv
rtl/header_builder.sv
rtl/frame_sequencer.sv
rtl/fcs_appender.sv
rtl/udp_frame_tx.sv
dv/tb_udp_frame_tx.sv

// ==== rtl/fcs_appender.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcs_appender
    import frame_gen_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    frame_stream_if.sink stream,
    output logic [7:0]   frame_data,
    output logic         frame_valid,
    output logic         frame_start,
    output logic         frame_last,
    output logic         frame_done
);

    // Reflected form of 0x04C11DB7
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT           = 32'hFFFFFFFF;

    logic [31:0] crc;
    logic [31:0] crc_next;
    logic        fcs_active;
    logic [1:0]  fcs_count;

    // LSB first, one bit per step
    function automatic logic [31:0] crc_byte(logic [31:0] crc_in, fg_byte_t data);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(stream.start ? CRC_INIT : crc, stream.data);

    //////////////////////////////////////////////////
    // Data path and FCS tail
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        frame_data <= fcs_active ? ~crc[7:0] : stream.data;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc         <= CRC_INIT;
            fcs_active  <= 1'b0;
            fcs_count   <= '0;
            frame_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_last  <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            frame_last  <= 1'b0;
            frame_done  <= 1'b0;
            if (fcs_active) begin
                // Shift out the complemented CRC, low byte first
                frame_valid <= 1'b1;
                crc         <= crc >> 8;
                fcs_count   <= fcs_count + 2'd1;
                if (fcs_count == 2'd3) begin
                    frame_last <= 1'b1;
                    frame_done <= 1'b1;
                    fcs_active <= 1'b0;
                end
            end else begin
                frame_valid <= stream.valid;
                if (stream.valid) begin
                    frame_start <= stream.start;
                    crc         <= crc_next;
                    if (stream.last) begin
                        fcs_active <= 1'b1;
                        fcs_count  <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_gen_cfg.svh ====
`ifndef FRAME_GEN_CFG_SVH
`define FRAME_GEN_CFG_SVH

//////////////////////////////////////////////////
// Payload buffer
//////////////////////////////////////////////////

`define FG_BUFFER_BYTES     2048
`define FG_ADDR_W           11

// 42 header bytes plus this gives a 60 byte frame before the FCS
`define FG_MIN_PAYLOAD      18

// Idle cycles between frame_done and ready
`define FG_GAP_CYCLES       15

//////////////////////////////////////////////////
// Protocol constants
//////////////////////////////////////////////////

`define FG_ETHERTYPE_IPV4   16'h0800
`define FG_IPV4_VER_IHL     8'h45
`define FG_IPV4_DSCP        8'h00
`define FG_IPV4_TTL         8'h80
`define FG_IPV4_PROTO_UDP   8'h11

`endif

// ==== rtl/frame_gen_pkg.sv ====
`default_nettype none

package frame_gen_pkg;

    typedef logic [7:0]  fg_byte_t;
    typedef logic [15:0] fg_word_t;

    //////////////////////////////////////////////////
    // IPv4 header, 20 bytes, no options
    //////////////////////////////////////////////////

    // Field order matches wire order, first byte in the top bits
    typedef struct packed {
        fg_byte_t    ver_ihl;
        fg_byte_t    dscp;
        fg_word_t    total_length;
        fg_word_t    identification;
        fg_word_t    flags;
        fg_byte_t    ttl;
        fg_byte_t    protocol;
        fg_word_t    checksum;
        logic [31:0] source;
        logic [31:0] destination;
    } ipv4_header_s;

    // Same 160 bits seen as fields, checksum words or wire bytes
    // words[9] and bytes[19] are the first on the wire
    typedef union packed {
        ipv4_header_s    fields;
        fg_word_t [9:0]  words;
        fg_byte_t [19:0] bytes;
    } ipv4_header_u;

endpackage

`default_nettype wire

// ==== rtl/frame_hdr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface frame_hdr_if
    import frame_gen_pkg::*;
();

    logic         hdr_valid;
    ipv4_header_u ipv4_header;
    logic [47:0]  mac_destination;
    logic [47:0]  mac_source;
    fg_word_t     udp_source;
    fg_word_t     udp_destination;
    fg_word_t     udp_checksum;
    fg_word_t     udp_payload_size;

    modport source (
        output hdr_valid, ipv4_header, mac_destination, mac_source,
        output udp_source, udp_destination, udp_checksum, udp_payload_size
    );

    modport sink (
        input hdr_valid, ipv4_header, mac_destination, mac_source,
        input udp_source, udp_destination, udp_checksum, udp_payload_size
    );

endinterface

`default_nettype wire

// ==== rtl/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_gen_cfg.svh"

module frame_sequencer
    import frame_gen_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [7:0]            buffer_read_data,
    output logic [`FG_ADDR_W-1:0] buffer_read_address,
    frame_hdr_if.sink             hdr,
    frame_stream_if.source        stream
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_HEADER,
        SEQ_PAYLOAD,
        SEQ_PAD
    } seq_state_t;

    // MACs, EtherType, IPv4 and UDP headers
    localparam int HEADER_BYTES = 42;

    seq_state_t                  state;
    logic [15:0]                 count;
    fg_word_t                    udp_length;
    fg_byte_t [HEADER_BYTES-1:0] header_bytes;
    fg_byte_t                    next_byte;
    logic                        payload_end;
    logic                        short_payload;

    assign udp_length = hdr.udp_payload_size + 16'd8;

    // Top byte goes out first
    assign header_bytes = {
        hdr.mac_destination,
        hdr.mac_source,
        16'(`FG_ETHERTYPE_IPV4),
        hdr.ipv4_header.bytes,
        hdr.udp_source,
        hdr.udp_destination,
        udp_length,
        hdr.udp_checksum
    };

    assign payload_end   = (count == hdr.udp_payload_size - 16'd1);
    assign short_payload = (hdr.udp_payload_size < 16'(`FG_MIN_PAYLOAD));

    always_comb begin
        case (state)
            SEQ_HEADER:  next_byte = header_bytes[count[5:0]];
            SEQ_PAYLOAD: next_byte = buffer_read_data;
            SEQ_PAD:     next_byte = '0;
            default:     next_byte = header_bytes[HEADER_BYTES-1];
        endcase
    end

    always_ff @(posedge clock) begin
        stream.data <= next_byte;
    end

    //////////////////////////////////////////////////
    // Byte walk
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state               <= SEQ_IDLE;
            count               <= '0;
            buffer_read_address <= '0;
            stream.valid        <= 1'b0;
            stream.start        <= 1'b0;
            stream.last         <= 1'b0;
        end else begin
            stream.start <= 1'b0;
            stream.last  <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    stream.valid <= hdr.hdr_valid;
                    if (hdr.hdr_valid) begin
                        // First header byte leaves on this edge
                        stream.start <= 1'b1;
                        count        <= 16'(HEADER_BYTES - 2);
                        state        <= SEQ_HEADER;
                    end
                end
                SEQ_HEADER: begin
                    stream.valid <= 1'b1;
                    if (count == 16'd0) begin
                        // Address 0 is already on the bus
                        buffer_read_address <= `FG_ADDR_W'(1);
                        state               <= SEQ_PAYLOAD;
                    end else begin
                        count <= count - 16'd1;
                    end
                end
                SEQ_PAYLOAD: begin
                    stream.valid <= 1'b1;
                    if (payload_end) begin
                        buffer_read_address <= '0;
                        if (short_payload) begin
                            count <= count + 16'd1;
                            state <= SEQ_PAD;
                        end else begin
                            stream.last <= 1'b1;
                            state       <= SEQ_IDLE;
                        end
                    end else begin
                        count               <= count + 16'd1;
                        buffer_read_address <= buffer_read_address + `FG_ADDR_W'(1);
                    end
                end
                SEQ_PAD: begin
                    stream.valid <= 1'b1;
                    if (count == 16'(`FG_MIN_PAYLOAD - 1)) begin
                        stream.last <= 1'b1;
                        state       <= SEQ_IDLE;
                    end else begin
                        count <= count + 16'd1;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface frame_stream_if
    import frame_gen_pkg::*;
();

    fg_byte_t data;
    logic     valid;
    // First byte of the frame
    logic     start;
    // Final payload or pad byte, FCS not included
    logic     last;

    modport source (
        output data, valid, start, last
    );

    modport sink (
        input data, valid, start, last
    );

endinterface

`default_nettype wire

// ==== rtl/header_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_gen_cfg.svh"

module header_builder
    import frame_gen_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        enable,
    input  logic [47:0] mac_destination,
    input  logic [47:0] mac_source,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    input  logic [15:0] ipv4_identification,
    input  logic [15:0] ipv4_flags,
    input  logic [15:0] udp_source,
    input  logic [15:0] udp_destination,
    input  logic [15:0] udp_checksum,
    input  logic [15:0] udp_payload_size,
    input  logic        frame_done,
    output logic        ready,
    frame_hdr_if.source hdr
);

    typedef enum logic [1:0] {
        HB_IDLE,
        HB_SUM,
        HB_WAIT,
        HB_GAP
    } hb_state_t;

    hb_state_t  state;
    // Word index while summing, gap countdown afterwards
    logic [3:0] count;
    fg_word_t   sum;
    fg_word_t   sum_next;
    logic       accept;

    // One's complement add with end-around carry
    function automatic fg_word_t ones_add(fg_word_t a, fg_word_t b);
        logic [16:0] total;
        total = {1'b0, a} + {1'b0, b};
        return total[15:0] + {15'd0, total[16]};
    endfunction

    assign accept   = ready && enable;
    assign sum_next = ones_add(sum, hdr.ipv4_header.words[count]);

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= HB_IDLE;
            ready         <= 1'b0;
            count         <= '0;
            sum           <= '0;
            hdr.hdr_valid <= 1'b0;
        end else begin
            hdr.hdr_valid <= 1'b0;
            case (state)
                HB_IDLE: begin
                    if (accept) begin
                        ready <= 1'b0;
                        count <= 4'd9;
                        sum   <= '0;
                        state <= HB_SUM;
                    end else begin
                        ready <= 1'b1;
                    end
                end
                HB_SUM: begin
                    // Checksum field is still zero during the sum
                    sum <= sum_next;
                    if (count == 4'd0) begin
                        hdr.hdr_valid <= 1'b1;
                        state         <= HB_WAIT;
                    end else begin
                        count <= count - 4'd1;
                    end
                end
                HB_WAIT: begin
                    if (frame_done) begin
                        count <= 4'(`FG_GAP_CYCLES - 2);
                        state <= HB_GAP;
                    end
                end
                HB_GAP: begin
                    if (count == 4'd0) begin
                        ready <= 1'b1;
                        state <= HB_IDLE;
                    end else begin
                        count <= count - 4'd1;
                    end
                end
                default: begin
                    state <= HB_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Latched header fields
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (accept) begin
            hdr.ipv4_header.fields.ver_ihl        <= `FG_IPV4_VER_IHL;
            hdr.ipv4_header.fields.dscp           <= `FG_IPV4_DSCP;
            hdr.ipv4_header.fields.total_length   <= udp_payload_size + 16'd28;
            hdr.ipv4_header.fields.identification <= ipv4_identification;
            hdr.ipv4_header.fields.flags          <= ipv4_flags;
            hdr.ipv4_header.fields.ttl            <= `FG_IPV4_TTL;
            hdr.ipv4_header.fields.protocol       <= `FG_IPV4_PROTO_UDP;
            hdr.ipv4_header.fields.checksum       <= '0;
            hdr.ipv4_header.fields.source         <= ipv4_source;
            hdr.ipv4_header.fields.destination    <= ipv4_destination;
            hdr.mac_destination                   <= mac_destination;
            hdr.mac_source                        <= mac_source;
            hdr.udp_source                        <= udp_source;
            hdr.udp_destination                   <= udp_destination;
            hdr.udp_checksum                      <= udp_checksum;
            hdr.udp_payload_size                  <= udp_payload_size;
        end else if (state == HB_SUM && count == 4'd0) begin
            hdr.ipv4_header.fields.checksum <= ~sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/udp_frame_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_gen_cfg.svh"

module udp_frame_tx (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enable,
    input  logic [47:0]           mac_destination,
    input  logic [47:0]           mac_source,
    input  logic [31:0]           ipv4_source,
    input  logic [31:0]           ipv4_destination,
    input  logic [15:0]           ipv4_identification,
    input  logic [15:0]           ipv4_flags,
    input  logic [15:0]           udp_source,
    input  logic [15:0]           udp_destination,
    input  logic [15:0]           udp_checksum,
    input  logic [15:0]           udp_payload_size,
    input  logic [7:0]            buffer_read_data,
    output logic                  ready,
    output logic [`FG_ADDR_W-1:0] buffer_read_address,
    output logic [7:0]            frame_data,
    output logic                  frame_valid,
    output logic                  frame_start,
    output logic                  frame_last
);

    logic frame_done;

    frame_hdr_if    hdr_link ();
    frame_stream_if stream_link ();

    //////////////////////////////////////////////////
    // Header, sequencer, FCS
    //////////////////////////////////////////////////

    header_builder i_header_builder (
        .clock               (clock),
        .reset_n             (reset_n),
        .enable              (enable),
        .mac_destination     (mac_destination),
        .mac_source          (mac_source),
        .ipv4_source         (ipv4_source),
        .ipv4_destination    (ipv4_destination),
        .ipv4_identification (ipv4_identification),
        .ipv4_flags          (ipv4_flags),
        .udp_source          (udp_source),
        .udp_destination     (udp_destination),
        .udp_checksum        (udp_checksum),
        .udp_payload_size    (udp_payload_size),
        .frame_done          (frame_done),
        .ready               (ready),
        .hdr                 (hdr_link.source)
    );

    frame_sequencer i_frame_sequencer (
        .clock               (clock),
        .reset_n             (reset_n),
        .buffer_read_data    (buffer_read_data),
        .buffer_read_address (buffer_read_address),
        .hdr                 (hdr_link.sink),
        .stream              (stream_link.source)
    );

    // Also reports the end of each frame back to the header stage
    fcs_appender i_fcs_appender (
        .clock       (clock),
        .reset_n     (reset_n),
        .stream      (stream_link.sink),
        .frame_data  (frame_data),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .frame_last  (frame_last),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire
